/* Bender.yml */
package:
  name: cps_gfx

sources:
  - files:
      - hw/cps_gfx_pkg.sv
      - hw/cps_fetch_if.sv
      - hw/cps_gfx_bank_map.sv
      - hw/cps_scroll_fetch.sv
      - hw/cps_gfx_arbiter.sv
      - hw/cps_gfx_top.sv
  - target: test
    files:
      - test/tb_cps_gfx.sv

/* hw/cps_fetch_if.sv */
`timescale 1ns/100ps

// one fetch unit to the arbiter
// requests are credit based, responses are unthrottled
interface cps_fetch_if import cps_gfx_pkg::*; ();

    logic      req_valid;  // one-cycle push into the layer queue
    gfx_addr_t req_addr;   // unmodified tile address
    logic      credit;     // pulses when the queue entry is popped
    logic      resp_valid; // pixel word for this layer
    rom_word_t resp_data;

    modport fetch (
        output req_valid,
        output req_addr,
        input  credit,
        input  resp_valid,
        input  resp_data
    );

    modport arb (
        input  req_valid,
        input  req_addr,
        output credit,
        output resp_valid,
        output resp_data
    );

endinterface

/* hw/cps_gfx_arbiter.sv */
`timescale 1ns/100ps

// shares the graphics rom between the three scroll layers
// one queue per layer, round-robin grant, one read in flight
module cps_gfx_arbiter import cps_gfx_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    cps_fetch_if.arb  scr1_if,
    cps_fetch_if.arb  scr2_if,
    cps_fetch_if.arb  scr3_if,
    output logic      rom_cs,
    output gfx_addr_t rom_addr,
    input  logic      rom_ok,
    input  rom_word_t rom_data
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    gfx_addr_t             q_mem     [NUM_LAYERS][QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr    [NUM_LAYERS];
    logic [PTR_W-1:0]      rd_ptr    [NUM_LAYERS];
    logic [CNT_W-1:0]      q_cnt     [NUM_LAYERS];
    gfx_addr_t             push_addr [NUM_LAYERS];
    gfx_addr_t             head_addr [NUM_LAYERS];
    bank_ofs_t             head_ofs  [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] push;
    logic [NUM_LAYERS-1:0] pop;
    logic [NUM_LAYERS-1:0] q_nonempty;
    logic [NUM_LAYERS-1:0] unmapped;    // per head, from the bank decode
    logic [NUM_LAYERS-1:0] resp_valid;
    arb_state_e            state;
    layer_e                rr_ptr;      // layer with top priority
    layer_e                pick;
    layer_e                grant_r;     // owner of the read in flight
    logic                  pick_valid;
    logic                  grant_go;
    gfx_addr_t             rom_addr_r;
    rom_word_t             rd_data;

    // wraps at QUEUE_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push[0]      = scr1_if.req_valid;
    assign push[1]      = scr2_if.req_valid;
    assign push[2]      = scr3_if.req_valid;
    assign push_addr[0] = scr1_if.req_addr;
    assign push_addr[1] = scr2_if.req_addr;
    assign push_addr[2] = scr3_if.req_addr;

    assign scr1_if.credit     = pop[0]; // credit leaves with the pop
    assign scr2_if.credit     = pop[1];
    assign scr3_if.credit     = pop[2];
    assign scr1_if.resp_valid = resp_valid[0];
    assign scr2_if.resp_valid = resp_valid[1];
    assign scr3_if.resp_valid = resp_valid[2];
    assign scr1_if.resp_data  = rd_data; // shared, qualified by resp_valid
    assign scr2_if.resp_data  = rd_data;
    assign scr3_if.resp_data  = rd_data;

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LAYERS; l++) begin
            if (push[l]) begin
                q_mem[l][wr_ptr[l]] <= push_addr[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LAYERS; l++) begin
                wr_ptr[l] <= '0;
                rd_ptr[l] <= '0;
                q_cnt[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < NUM_LAYERS; l++) begin
                if (push[l]) wr_ptr[l] <= ptr_next(wr_ptr[l]);
                if (pop[l])  rd_ptr[l] <= ptr_next(rd_ptr[l]);
                if (push[l] && !pop[l]) begin
                    q_cnt[l] <= q_cnt[l] + 1'b1;
                end else if (!push[l] && pop[l]) begin
                    q_cnt[l] <= q_cnt[l] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LAYERS; l++) begin
            head_addr[l]  = q_mem[l][rd_ptr[l]];
            q_nonempty[l] = (q_cnt[l] != '0);
        end
    end

    // all three heads decoded at once, grant picks one
    cps_gfx_bank_map u_bank_map (
        .scr1_addr     (head_addr[0]),
        .scr2_addr     (head_addr[1]),
        .scr3_addr     (head_addr[2]),
        .scr1_ofs      (head_ofs[0]),
        .scr2_ofs      (head_ofs[1]),
        .scr3_ofs      (head_ofs[2]),
        .scr1_unmapped (unmapped[0]),
        .scr2_unmapped (unmapped[1]),
        .scr3_unmapped (unmapped[2])
    );

    // scan downwards so the layer at rr_ptr wins last
    always_comb begin
        int idx;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_LAYERS;
            if (q_nonempty[idx]) begin
                pick       = layer_e'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    assign grant_go = (state == ARB_IDLE) && pick_valid;

    always_comb begin
        pop = '0;
        if (grant_go) pop[pick] = 1'b1; // grant and pop in one cycle
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ARB_IDLE;
            rr_ptr <= LAYER_SCR1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant_go) begin
                        rr_ptr <= (pick == LAYER_SCR3) ? LAYER_SCR1 : layer_e'(pick + 1'b1);
                        state  <= unmapped[pick] ? ARB_RESP : ARB_ROM; // skip the rom
                    end
                end
                ARB_ROM:  if (rom_ok) state <= ARB_RESP;
                ARB_RESP: state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_go) begin
            grant_r    <= pick;
            rom_addr_r <= {head_addr[pick][22:19] + head_ofs[pick], head_addr[pick][18:0]};
            rd_data    <= '0; // stays zero for unmapped heads
        end else if ((state == ARB_ROM) && rom_ok) begin
            rd_data    <= rom_data;
        end
    end

    assign rom_cs   = (state == ARB_ROM); // drops on the edge after rom_ok
    assign rom_addr = rom_addr_r;

    always_comb begin
        resp_valid = '0;
        if (state == ARB_RESP) resp_valid[grant_r] = 1'b1;
    end

endmodule

/* hw/cps_gfx_bank_map.sv */
`timescale 1ns/100ps

// bank select decode for the three scroll lanes
// same equations as the board's gal, evaluated per lane
module cps_gfx_bank_map import cps_gfx_pkg::*; (
    input  gfx_addr_t scr1_addr,
    input  gfx_addr_t scr2_addr,
    input  gfx_addr_t scr3_addr,
    output bank_ofs_t scr1_ofs,
    output bank_ofs_t scr2_ofs,
    output bank_ofs_t scr3_ofs,
    output logic      scr1_unmapped,
    output logic      scr2_unmapped,
    output logic      scr3_unmapped
);

    bank_en_t scr1_en;
    bank_en_t scr2_en;
    bank_en_t scr3_en;

    // only a[22:20] and a[16] reach the decoder
    function automatic bank_en_t bank_decode(input gfx_addr_t a);
        bank_en_t en;
        // bank 1, three product terms
        en[0] = ~a[22] & ((~a[21] & a[20]) | (~a[20] & ~a[16]) | (a[21] & ~a[20]));
        en[1] = ({a[22:20], a[16]} == 4'b0110); // bank 2, region 011 low half
        en[2] = ({a[22:20], a[16]} == 4'b0001); // bank 3, region 000 high half
        return en;
    endfunction

    // only bank 1 on its own moves the address
    function automatic bank_ofs_t bank_offset(input bank_en_t en);
        bank_ofs_t ofs;
        case (en)
            3'b001:  ofs = 4'h4;
            default: ofs = 4'h0; // bank 2, bank 3, overlaps, none
        endcase
        return ofs;
    endfunction

    always_comb begin
        scr1_en = bank_decode(scr1_addr);
        scr2_en = bank_decode(scr2_addr);
        scr3_en = bank_decode(scr3_addr);
    end

    assign scr1_ofs = bank_offset(scr1_en);
    assign scr2_ofs = bank_offset(scr2_en);
    assign scr3_ofs = bank_offset(scr3_en);

    // no chip select at all, nothing on the rom answers
    assign scr1_unmapped = (scr1_en == '0);
    assign scr2_unmapped = (scr2_en == '0);
    assign scr3_unmapped = (scr3_en == '0);

endmodule

/* hw/cps_gfx_pkg.sv */
package cps_gfx_pkg;

    // three scroll lanes, the bank decode has exactly this many
    localparam int NUM_LAYERS = 3;

    // scroll layer select, also used as the arbiter grant
    typedef enum logic [1:0] {
        LAYER_SCR1 = 2'd0,
        LAYER_SCR2 = 2'd1,
        LAYER_SCR3 = 2'd2
    } layer_e;

    // rom read sequencer
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0, // waiting for a queue head
        ARB_ROM  = 2'd1, // rom_cs high until rom_ok
        ARB_RESP = 2'd2  // one cycle of resp_valid
    } arb_state_e;

    // tile code as sent by the host
    typedef logic [19:0] tile_code_t;

    // row inside a tile
    // scr1 uses 3 bits, scr2 uses 4, scr3 all 5
    typedef logic [4:0] tile_row_t;

    // graphics rom address
    // [22:20] region: 000 obj, 001..011 scroll 1..3, 100 star field
    typedef logic [22:0] gfx_addr_t;

    // bank enables, bit 0 is bank 1
    typedef logic [2:0] bank_en_t;

    // offset added to the top nibble of the address
    typedef logic [3:0] bank_ofs_t;

    // rom data, one word of packed pixels
    typedef logic [31:0] rom_word_t;

endpackage

/* hw/cps_gfx_top.sv */
`timescale 1ns/100ps

// scroll layer graphics fetch path
// host tile fetches in, rom reads out, pixel words back per layer
module cps_gfx_top import cps_gfx_pkg::*; #(
    parameter int QUEUE_DEPTH = 2 // per layer arbiter queue, 1 to 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid  [NUM_LAYERS],
    input  tile_code_t req_code   [NUM_LAYERS],
    input  tile_row_t  req_row    [NUM_LAYERS],
    output logic       req_credit [NUM_LAYERS],
    output logic       pix_valid  [NUM_LAYERS],
    output rom_word_t  pix_data   [NUM_LAYERS],
    output logic       rom_cs,
    output gfx_addr_t  rom_addr,
    input  logic       rom_ok,
    input  rom_word_t  rom_data
);

    // one link per layer into the arbiter
    cps_fetch_if scr1_bus ();
    cps_fetch_if scr2_bus ();
    cps_fetch_if scr3_bus ();

    cps_scroll_fetch #(
        .LAYER       (LAYER_SCR1),  // 8 row tiles
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_scr1_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid[0]),
        .req_code   (req_code[0]),
        .req_row    (req_row[0]),
        .req_credit (req_credit[0]),
        .pix_valid  (pix_valid[0]),
        .pix_data   (pix_data[0]),
        .fetch_if   (scr1_bus.fetch)
    );

    cps_scroll_fetch #(
        .LAYER       (LAYER_SCR2),  // 16 row tiles
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_scr2_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid[1]),
        .req_code   (req_code[1]),
        .req_row    (req_row[1]),
        .req_credit (req_credit[1]),
        .pix_valid  (pix_valid[1]),
        .pix_data   (pix_data[1]),
        .fetch_if   (scr2_bus.fetch)
    );

    cps_scroll_fetch #(
        .LAYER       (LAYER_SCR3),  // 32 row tiles
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_scr3_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid[2]),
        .req_code   (req_code[2]),
        .req_row    (req_row[2]),
        .req_credit (req_credit[2]),
        .pix_valid  (pix_valid[2]),
        .pix_data   (pix_data[2]),
        .fetch_if   (scr3_bus.fetch)
    );

    cps_gfx_arbiter #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .scr1_if  (scr1_bus.arb),
        .scr2_if  (scr2_bus.arb),
        .scr3_if  (scr3_bus.arb),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

endmodule

/* hw/cps_scroll_fetch.sv */
`timescale 1ns/100ps

// tile fetch front end for one scroll layer
// host item -> holding register -> arbiter queue, pixel word back out
module cps_scroll_fetch import cps_gfx_pkg::*; #(
    parameter layer_e LAYER       = LAYER_SCR1,
    parameter int     QUEUE_DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  tile_code_t       req_code,
    input  tile_row_t        req_row,
    output logic             req_credit,
    output logic             pix_valid,
    output rom_word_t        pix_data,
    cps_fetch_if.fetch       fetch_if
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [24:0]      addr_wide;  // code plus up to 5 row bits
    gfx_addr_t        addr_new;
    logic             hold_valid; // holding register full
    gfx_addr_t        hold_addr;
    logic [CNT_W-1:0] arb_cnt;    // free slots in our arbiter queue
    logic             push;

    // row width depends on the layer tile height
    always_comb begin
        case (LAYER)
            LAYER_SCR1: addr_wide = {2'b00, req_code, req_row[2:0]}; // 8 rows
            LAYER_SCR2: addr_wide = {1'b0, req_code, req_row[3:0]};  // 16 rows
            default:    addr_wide = {req_code, req_row};             // 32 rows
        endcase
    end

    assign addr_new = addr_wide[22:0]; // top code bits fall off

    // push as soon as the item is held and the queue has room
    assign push = hold_valid && (arb_cnt != '0);

    assign fetch_if.req_valid = push;
    assign fetch_if.req_addr  = hold_addr;

    // host gets its single credit back when the item moves on
    assign req_credit = push;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (req_valid) begin
            hold_valid <= 1'b1; // host only sends while holding a credit
        end else if (push) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            hold_addr <= addr_new;
        end
    end

    // arbiter credit counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arb_cnt <= CNT_W'(QUEUE_DEPTH); // whole queue free
        end else begin
            case ({push, fetch_if.credit})
                2'b10:   arb_cnt <= arb_cnt - 1'b1; // slot taken
                2'b01:   arb_cnt <= arb_cnt + 1'b1; // slot popped
                default: arb_cnt <= arb_cnt;        // none or both
            endcase
        end
    end

    // registered pixel output, no back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= fetch_if.resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_if.resp_valid) begin
            pix_data <= fetch_if.resp_data;
        end
    end

endmodule

/* src.f */
hw/cps_gfx_pkg.sv
hw/cps_fetch_if.sv
hw/cps_gfx_bank_map.sv
hw/cps_scroll_fetch.sv
hw/cps_gfx_arbiter.sv
hw/cps_gfx_top.sv
test/tb_cps_gfx.sv

/* test/tb_cps_gfx.sv */
`timescale 1ns/100ps

module tb_cps_gfx import cps_gfx_pkg::*; ();

    localparam int WAIT_LIMIT   = 2000; // cycles per wait loop
    localparam int RAND_FETCHES = 24;   // per layer in the mixed run

    logic       clk = 1'b0;
    logic       rst_n;
    logic       req_valid  [NUM_LAYERS];
    tile_code_t req_code   [NUM_LAYERS];
    tile_row_t  req_row    [NUM_LAYERS];
    logic       req_credit [NUM_LAYERS];
    logic       pix_valid  [NUM_LAYERS];
    rom_word_t  pix_data   [NUM_LAYERS];
    logic       rom_cs;
    gfx_addr_t  rom_addr;
    logic       rom_ok   = 1'b0;
    rom_word_t  rom_data = '0;

    int         seed       = 32'h5e6f3204;
    int         rom_wait   = 0;          // cycles left before rom_ok
    int         rom_cycles = 0;          // cycles with rom_cs high
    int         sent   [NUM_LAYERS] = '{default: 0};
    int         pulses [NUM_LAYERS] = '{default: 0};
    rom_word_t  exp_q  [NUM_LAYERS][$];  // expected words, in send order
    tile_row_t  row_set [7] = '{5'd0, 5'd5, 5'd7, 5'd8, 5'd15, 5'd16, 5'd31};
    string      test_name = "reset";
    int         errors = 0;
    int         checks = 0;
    int         tests  = 0;
    int         test_err0 = 0;

    cps_gfx_top #(
        .QUEUE_DEPTH (2)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_code   (req_code),
        .req_row    (req_row),
        .req_credit (req_credit),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data)
    );

    always #10 clk = ~clk; // 20 ns period

    function automatic int row_bits(input layer_e l);
        case (l)
            LAYER_SCR1: return 3; // 8 row tiles
            LAYER_SCR2: return 4;
            default:    return 5; // 32 row tiles
        endcase
    endfunction

    // what the rom holds at an address
    function automatic rom_word_t rom_model_data(input gfx_addr_t a);
        return rom_word_t'(a) ^ 32'h5a5a0000;
    endfunction

    // code that lands in a chosen region and half for this layer
    function automatic tile_code_t make_code(input layer_e l, input logic [2:0] region,
                                             input logic b16, input logic [15:0] low);
        gfx_addr_t a;
        a = {region, 3'b000, b16, low};
        return tile_code_t'(a >> row_bits(l));
    endfunction

    // expected pixel word for one host fetch
    function automatic rom_word_t expected_word(input layer_e l, input tile_code_t code,
                                                input tile_row_t row);
        int        w;
        gfx_addr_t a;
        logic      b1;
        logic      b2;
        logic      b3;
        bank_ofs_t ofs;
        w  = row_bits(l);
        a  = gfx_addr_t'((25'(code) << w) | (25'(row) & ((25'd1 << w) - 1)));
        b1 = !a[22] && ((!a[21] && a[20]) || (!a[20] && !a[16]) || (a[21] && !a[20]));
        b2 = (a[22:20] == 3'b011) && !a[16];
        b3 = (a[22:20] == 3'b000) && a[16];
        if (!b1 && !b2 && !b3) return '0; // nothing selected, zero word
        ofs = (b1 && !b2 && !b3) ? 4'h4 : 4'h0;
        a[22:19] = a[22:19] + ofs; // wraps in the nibble
        return rom_model_data(a);
    endfunction

    task automatic check_word(input string name, input rom_word_t exp, input rom_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_err0) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, errors - test_err0);
    endtask

    // items still owed: queued words plus host credits not yet back
    function automatic int pending();
        int n;
        n = 0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            n += exp_q[l].size() + sent[l] - pulses[l];
        end
        return n;
    endfunction

    // call on a rising edge, returns on one
    task automatic send_fetch(input int l, input tile_code_t code, input tile_row_t row);
        int waited;
        waited = 0;
        while (sent[l] != pulses[l] && waited < WAIT_LIMIT) begin // host credit
            @(posedge clk);
            waited++;
        end
        if (sent[l] != pulses[l]) begin
            note_failure($sformatf("layer %0d never got its host credit back", l));
        end else begin
            exp_q[l].push_back(expected_word(layer_e'(l), code, row));
            req_valid[l] <= 1'b1;
            req_code[l]  <= code;
            req_row[l]   <= row;
            sent[l]      <= sent[l] + 1;
            @(posedge clk);
            req_valid[l] <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending() != 0) note_failure("traffic did not drain before the timeout");
    endtask

    task automatic random_traffic(input int l);
        repeat (RAND_FETCHES) begin
            send_fetch(l, tile_code_t'($random(seed)), tile_row_t'($random(seed)));
        end
    endtask

    // rom with a random wait, rom_ok for one cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            rom_ok   <= 1'b0;
            rom_wait <= 0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0; // rom_cs drops on this edge too
        end else if (rom_cs && rom_wait == 0) begin
            rom_wait <= 1 + ($unsigned($random(seed)) % 4);
        end else if (rom_wait == 1) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_model_data(rom_addr);
            rom_wait <= 0;
        end else if (rom_wait > 1) begin
            rom_wait <= rom_wait - 1;
        end
    end

    // compare process that also counts credits and rom activity
    // samples mid cycle where dut outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (rom_cs) rom_cycles <= rom_cycles + 1;
            for (int l = 0; l < NUM_LAYERS; l++) begin
                if (req_credit[l]) begin
                    if (pulses[l] >= sent[l]) begin
                        note_failure($sformatf("layer %0d got a credit with none owed", l));
                    end
                    pulses[l] <= pulses[l] + 1;
                end
                if (pix_valid[l]) begin
                    if (exp_q[l].size() == 0) begin
                        note_failure($sformatf("layer %0d gave a word nobody asked for", l));
                    end else begin
                        check_word($sformatf("%s layer %0d", test_name, l),
                                   exp_q[l].pop_front(), pix_data[l]);
                    end
                end
            end
        end
    end

    initial begin
        int busy;
        int base;
        busy  = 0;
        rst_n = 1'b0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            req_valid[l] = 1'b0;
            req_code[l]  = '0;
            req_row[l]   = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset_idle"); // outputs quiet until the first request
        repeat (12) begin
            @(posedge clk);
            for (int l = 0; l < NUM_LAYERS; l++) begin
                if (pix_valid[l] !== 1'b0 || req_credit[l] !== 1'b0) busy++; // x counts too
            end
            if (rom_cs !== 1'b0) busy++;
        end
        check_count("reset_idle busy cycles", 0, busy);
        end_test();

        begin_test("bank_select"); // one at a time, each bank pattern
        for (int l = 0; l < NUM_LAYERS; l++) begin
            send_fetch(l, make_code(layer_e'(l), 3'b001, 1'b0, 16'h1234), 5'd3); // +4
            wait_drain();
            send_fetch(l, make_code(layer_e'(l), 3'b011, 1'b0, 16'h0ff0), 5'd1); // bank 2
            wait_drain();
            send_fetch(l, make_code(layer_e'(l), 3'b000, 1'b1, 16'h8001), 5'd6); // bank 3
            wait_drain();
            send_fetch(l, make_code(layer_e'(l), 3'b010, 1'b1, 16'h00a5), 5'd2);
            wait_drain();
        end
        end_test();

        begin_test("unmapped");
        base = rom_cycles;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            send_fetch(l, make_code(layer_e'(l), 3'b100, 1'b1, 16'h4321), 5'd9); // star field
            send_fetch(l, make_code(layer_e'(l), 3'b111, 1'b0, 16'h0007), 5'd0);
            send_fetch(l, make_code(layer_e'(l), 3'b011, 1'b1, 16'hbeef), 5'd31);
        end
        wait_drain();
        check_count("unmapped rom_cs cycles", 0, rom_cycles - base);
        end_test();

        begin_test("row_width"); // same code, rows past the tile height wrap
        for (int l = 0; l < NUM_LAYERS; l++) begin
            foreach (row_set[i]) send_fetch(l, 20'h0a5c3, row_set[i]);
        end
        wait_drain();
        end_test();

        begin_test("random_mix"); // all layers at full credit rate
        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join
        wait_drain();
        end_test();

        begin_test("credit_count");
        for (int l = 0; l < NUM_LAYERS; l++) begin
            check_count($sformatf("credit_count layer %0d", l), sent[l], pulses[l]);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
